// File: verilog.f
hdl/adpcm_pkg.sv
hdl/adpcm_req_decode.sv
hdl/adpcm_fetch_exec.sv
hdl/adpcm_byte_result.sv
hdl/voice_rom_loader.sv
hdl/adpcm_fetch_top.sv
bench/sample_mem_model.sv
bench/tb_adpcm_fetch.sv

// File: Makefile
# Verilator build and run for the ADPCM sample memory path

VERILATOR ?= verilator
TOP       ?= tb_adpcm_fetch
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST := verilog.f
SOURCES  := $(wildcard hdl/*.sv bench/*.sv)
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_adpcm_fetch.sv
// ADPCM fetch testbench
`timescale 1ns/1ps

module tb_adpcm_fetch;

	// Generous bound over the whole run
	localparam int unsigned TIMEOUT_CYCLES = 20000;
	localparam adpcm_pkg::pcm_word_t FILL_KEY = 16'hc3a5;

	logic                                        clk_sys;
	logic                                        nRESET;
	logic [adpcm_pkg::ADPCMA_ADDR_W-1:0]         adpcma_addr;
	logic [adpcm_pkg::ADPCMA_BANK_W-1:0]         adpcma_bank;
	logic                                        adpcma_roe_n;
	adpcm_pkg::pcm_byte_t                        adpcma_data;
	logic [adpcm_pkg::ADPCMB_ADDR_W-1:0]         adpcmb_addr;
	logic                                        adpcmb_roe_n;
	adpcm_pkg::pcm_byte_t                        adpcmb_data;
	logic                                        use_pcm;
	logic                                        ioctl_download;
	logic                                        ioctl_wr;
	logic [adpcm_pkg::PCM_BYTE_ADDR_W-1:0]       ioctl_addr;
	adpcm_pkg::pcm_word_t                        ioctl_dout;
	logic [adpcm_pkg::IOCTL_INDEX_W-1:0]         ioctl_index;
	logic                                        ioctl_wait;
	adpcm_pkg::pcm_word_addr_t                   rd_addr;
	logic                                        rd_req;
	logic                                        rd_ack;
	adpcm_pkg::pcm_word_t                        rd_data;
	adpcm_pkg::pcm_word_addr_t                   wr_addr;
	adpcm_pkg::pcm_word_t                        wr_data;
	logic                                        wr_req;
	logic                                        wr_ack;

	// Reference copy of every written word and where the words went
	adpcm_pkg::pcm_word_t                        ref_mem [adpcm_pkg::pcm_word_addr_t];
	adpcm_pkg::pcm_byte_addr_t                   written_q [$];
	int unsigned                                 cycle_count;
	// Last byte each channel should hold
	adpcm_pkg::pcm_byte_t                        exp_a_data;
	adpcm_pkg::pcm_byte_t                        exp_b_data;

	adpcm_fetch_top adpcm_fetch_top_inst (.*);

	sample_mem_model #(.FILL_KEY(FILL_KEY)) sample_mem_model_inst (.*);

	// ======================================================================
	// Clock and timeout
	// ======================================================================

	initial
	begin
		clk_sys = 1'b0;
		forever
			#2 clk_sys = ~clk_sys;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
		abort_run();
	end

	// ======================================================================
	// Helpers and compare tasks
	// ======================================================================

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Step to 1 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input adpcm_pkg::pcm_byte_t got,
		input adpcm_pkg::pcm_byte_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_word_addr(input string name, input adpcm_pkg::pcm_word_addr_t got,
		input adpcm_pkg::pcm_word_addr_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Expected byte from the reference copy or the fill rule
	function automatic adpcm_pkg::pcm_byte_t expect_byte(input adpcm_pkg::pcm_byte_addr_t ba);
		adpcm_pkg::pcm_word_addr_t wa;
		adpcm_pkg::pcm_word_t      w;
		wa = ba[24:1];
		if (ref_mem.exists(wa))
			w = ref_mem[wa];
		else
			w = (wa[15:0] ^ FILL_KEY) + {8'h00, wa[23:16]};
		return ba[0] ? w[15:8] : w[7:0];
	endfunction

	// About half the picks hit a downloaded word
	function automatic adpcm_pkg::pcm_byte_addr_t pick_addr();
		int unsigned               r;
		adpcm_pkg::pcm_byte_addr_t ba;
		r  = $urandom();
		ba = r[24:0];
		if (r[31] && written_q.size() > 0)
		begin
			ba    = written_q[$urandom() % written_q.size()];
			ba[0] = r[0];
		end
		return ba;
	endfunction

	// ======================================================================
	// Download and fetch sequences
	// ======================================================================

	// One download write
	// Non voice ROM indexes must not reach the memory
	task automatic load_word(input logic [7:0] index);
		adpcm_pkg::pcm_byte_addr_t ba;
		adpcm_pkg::pcm_byte_addr_t full;
		adpcm_pkg::pcm_word_t      data;
		logic                      req_before;
		int unsigned               r;
		r          = $urandom();
		ba         = {6'd0, r[18:1], 1'b0};
		r          = $urandom();
		data       = r[15:0];
		full       = {17'd0, index - adpcm_pkg::INDEX_VROMS} << adpcm_pkg::VROM_SLOT_SHIFT;
		full       = full + ba;
		req_before = wr_req;
		ioctl_index = index;
		ioctl_addr  = ba;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		next_cycle();
		ioctl_wr    = 1'b0;
		if (index < adpcm_pkg::INDEX_VROMS || index >= adpcm_pkg::INDEX_CROMS)
		begin
			check_bit("wr_req", wr_req, req_before);
			check_bit("ioctl_wait", ioctl_wait, 1'b0);
		end
		else
		begin
			// Toggle and wait rise on the same edge
			check_bit("wr_req", wr_req, ~req_before);
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			check_word_addr("wr_addr", wr_addr, full[24:1]);
			while (wr_ack != wr_req)
			begin
				check_bit("ioctl_wait", ioctl_wait, 1'b1);
				next_cycle();
			end
			// Wait drops on the edge after the acknowledge
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			next_cycle();
			check_bit("ioctl_wait", ioctl_wait, 1'b0);
			ref_mem[full[24:1]] = data;
			written_q.push_back(full);
		end
	endtask

	// Follow one read
	// Data is due 2 cycles after rd_ack settles
	task automatic finish_read(input adpcm_pkg::adpcm_chan_t chan,
		input adpcm_pkg::pcm_byte_addr_t ba);
		while (rd_req == rd_ack)
			next_cycle();
		check_word_addr("rd_addr", rd_addr, ba[24:1]);
		while (rd_req != rd_ack)
			next_cycle();
		repeat (2)
			next_cycle();
		if (chan == adpcm_pkg::chan_b)
			exp_b_data = expect_byte(ba);
		else
			exp_a_data = expect_byte(ba);
		// The other channel keeps its last byte
		check_byte("adpcma_data", adpcma_data, exp_a_data);
		check_byte("adpcmb_data", adpcmb_data, exp_b_data);
	endtask

	// Strobe the chosen channels together
	// B is expected first
	task automatic serve(input logic do_a, input logic do_b);
		adpcm_pkg::pcm_byte_addr_t ba_a;
		adpcm_pkg::pcm_byte_addr_t ba_b;
		ba_a         = pick_addr();
		ba_a[24]     = 1'b0;
		ba_b         = pick_addr();
		ba_b[24]     = ~use_pcm;
		adpcma_bank  = ba_a[23:20];
		adpcma_addr  = ba_a[19:0];
		adpcmb_addr  = ba_b[23:0];
		adpcma_roe_n = ~do_a;
		adpcmb_roe_n = ~do_b;
		next_cycle();
		adpcma_roe_n = 1'b1;
		adpcmb_roe_n = 1'b1;
		if (do_b)
			finish_read(adpcm_pkg::chan_b, ba_b);
		if (do_a)
			finish_read(adpcm_pkg::chan_a, ba_a);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial
	begin
		int unsigned r;
		void'($urandom(32'h80cd_4a20));
		nRESET         = 1'b0;
		adpcma_addr    = '0;
		adpcma_bank    = '0;
		adpcma_roe_n   = 1'b1;
		adpcmb_addr    = '0;
		adpcmb_roe_n   = 1'b1;
		use_pcm        = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		exp_a_data     = '0;
		exp_b_data     = '0;
		repeat (4)
			@(posedge clk_sys);
		#1;
		nRESET = 1'b1;
		// Quiet link and cleared data after reset
		check_bit("rd_req", rd_req, 1'b0);
		check_bit("wr_req", wr_req, 1'b0);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_byte("adpcma_data", adpcma_data, 8'h00);
		check_byte("adpcmb_data", adpcmb_data, 8'h00);

		// Voice ROM download over indexes 16 to 19 with stray indexes mixed in
		ioctl_download = 1'b1;
		for (int i = 0; i < 200; i++)
		begin
			if (i % 40 == 7)
				load_word(8'd8);
			if (i % 40 == 27)
				load_word(8'd64);
			load_word(8'd16 + 8'($urandom() % 4));
		end

		// Same word again, then the download ends while the write is outstanding
		ioctl_wr = 1'b1;
		next_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		check_bit("ioctl_wait", ioctl_wait, 1'b1);
		next_cycle();
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		while (wr_ack != wr_req)
			next_cycle();

		repeat (20)
			serve(1'b1, 1'b0);
		// Channel B top bit follows ~use_pcm
		use_pcm = 1'b0;
		repeat (10)
			serve(1'b0, 1'b1);
		use_pcm = 1'b1;
		repeat (10)
			serve(1'b0, 1'b1);
		repeat (10)
			serve(1'b1, 1'b1);

		// Random mix with random gaps
		for (int i = 0; i < 300; i++)
		begin
			r       = $urandom();
			use_pcm = r[4];
			repeat (r[7:5])
				next_cycle();
			serve(r[1:0] != 2'd1, r[1:0] != 2'd0);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// File: bench/sample_mem_model.sv
// Sample memory model
`timescale 1ns/1ps

module sample_mem_model
#(
	parameter adpcm_pkg::pcm_word_t FILL_KEY = 16'hc3a5
)
(
	input  logic                       clk_sys,
	input  logic                       nRESET,
	input  adpcm_pkg::pcm_word_addr_t  rd_addr,
	input  logic                       rd_req,
	output logic                       rd_ack,
	output adpcm_pkg::pcm_word_t       rd_data,
	input  adpcm_pkg::pcm_word_addr_t  wr_addr,
	input  adpcm_pkg::pcm_word_t       wr_data,
	input  logic                       wr_req,
	output logic                       wr_ack
);

	// Sparse storage, only downloaded words exist
	adpcm_pkg::pcm_word_t mem [adpcm_pkg::pcm_word_addr_t];
	// Cycles left before each side answers, 0 when idle
	int unsigned          rd_left;
	int unsigned          wr_left;

	// Unwritten words read back a pattern of their whole address
	function automatic adpcm_pkg::pcm_word_t word_at(input adpcm_pkg::pcm_word_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return (a[15:0] ^ FILL_KEY) + {8'h00, a[23:16]};
	endfunction

	// ======================================================================
	// Read side, answers 2 to 9 cycles after the toggle
	// ======================================================================

	always @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			rd_ack  <= 1'b0;
			rd_data <= '0;
			rd_left <= 0;
		end
		else if (rd_left == 0)
		begin
			if (rd_req != rd_ack)
				rd_left <= 2 + $urandom() % 8;
		end
		else if (rd_left == 1)
		begin
			// Data and ack move together
			rd_data <= word_at(rd_addr);
			rd_ack  <= rd_req;
			rd_left <= 0;
		end
		else
			rd_left <= rd_left - 1;
	end

	// ======================================================================
	// Write side, independent of reads
	// ======================================================================

	always @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			wr_ack  <= 1'b0;
			wr_left <= 0;
		end
		else if (wr_left == 0)
		begin
			if (wr_req != wr_ack)
				wr_left <= 2 + $urandom() % 8;
		end
		else if (wr_left == 1)
		begin
			// Word lands when the ack goes out
			mem[wr_addr] = wr_data;
			wr_ack  <= wr_req;
			wr_left <= 0;
		end
		else
			wr_left <= wr_left - 1;
	end

endmodule

// File: hdl/adpcm_fetch_top.sv
// ADPCM sample memory top
`timescale 1ns/1ps

module adpcm_fetch_top
(
	input  logic                                   clk_sys,
	input  logic                                   nRESET,
	// Channel A
	input  logic [adpcm_pkg::ADPCMA_ADDR_W-1:0]    adpcma_addr,
	input  logic [adpcm_pkg::ADPCMA_BANK_W-1:0]    adpcma_bank,
	input  logic                                   adpcma_roe_n,
	output adpcm_pkg::pcm_byte_t                   adpcma_data,
	// Channel B
	input  logic [adpcm_pkg::ADPCMB_ADDR_W-1:0]    adpcmb_addr,
	input  logic                                   adpcmb_roe_n,
	output adpcm_pkg::pcm_byte_t                   adpcmb_data,
	input  logic                                   use_pcm,
	// Download
	input  logic                                   ioctl_download,
	input  logic                                   ioctl_wr,
	input  logic [adpcm_pkg::PCM_BYTE_ADDR_W-1:0]  ioctl_addr,
	input  adpcm_pkg::pcm_word_t                   ioctl_dout,
	input  logic [adpcm_pkg::IOCTL_INDEX_W-1:0]    ioctl_index,
	output logic                                   ioctl_wait,
	// Sample memory, toggle link
	output adpcm_pkg::pcm_word_addr_t              rd_addr,
	output logic                                   rd_req,
	input  logic                                   rd_ack,
	input  adpcm_pkg::pcm_word_t                   rd_data,
	output adpcm_pkg::pcm_word_addr_t              wr_addr,
	output adpcm_pkg::pcm_word_t                   wr_data,
	output logic                                   wr_req,
	input  logic                                   wr_ack
);

	logic                   pend_a;
	logic                   pend_b;
	adpcm_pkg::adpcm_req_t  req_a;
	adpcm_pkg::adpcm_req_t  req_b;
	logic                   grant;
	adpcm_pkg::adpcm_chan_t grant_chan;
	logic                   done;
	adpcm_pkg::adpcm_req_t  done_req;

	// ======================================================================
	// Fetch path, decode then execute then result
	// ======================================================================

	adpcm_req_decode adpcm_req_decode_inst (.*);

	adpcm_fetch_exec adpcm_fetch_exec_inst (.*);

	adpcm_byte_result adpcm_byte_result_inst (.*);

	// Download path, writes only
	voice_rom_loader voice_rom_loader_inst (.*);

endmodule

// File: hdl/voice_rom_loader.sv
// Voice ROM download loader
`timescale 1ns/1ps

module voice_rom_loader
(
	input  logic                                   clk_sys,
	input  logic                                   nRESET,
	input  logic                                   ioctl_download,
	input  logic                                   ioctl_wr,
	input  logic [adpcm_pkg::PCM_BYTE_ADDR_W-1:0]  ioctl_addr,
	input  logic [adpcm_pkg::IOCTL_INDEX_W-1:0]    ioctl_index,
	input  adpcm_pkg::pcm_word_t                   ioctl_dout,
	output logic                                   ioctl_wait,
	output adpcm_pkg::pcm_word_addr_t              wr_addr,
	output adpcm_pkg::pcm_word_t                   wr_data,
	output logic                                   wr_req,
	input  logic                                   wr_ack
);

	logic                                pcm_loading;
	logic [adpcm_pkg::IOCTL_INDEX_W-1:0] slot;
	adpcm_pkg::pcm_byte_addr_t           load_addr;

	// ======================================================================
	// Slot address
	// ======================================================================

	// Only voice ROM indexes go to sample memory
	assign pcm_loading = ioctl_download &&
		(ioctl_index >= adpcm_pkg::INDEX_VROMS) &&
		(ioctl_index < adpcm_pkg::INDEX_CROMS);

	// 512 KB per index above the first voice ROM
	assign slot      = ioctl_index - adpcm_pkg::INDEX_VROMS;
	assign load_addr = ioctl_addr +
		(adpcm_pkg::pcm_byte_addr_t'(slot) << adpcm_pkg::VROM_SLOT_SHIFT);

	// ======================================================================
	// Write toggle and wait flag
	// ======================================================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			wr_req     <= 1'b0;
			ioctl_wait <= 1'b0;
		end
		else if (!pcm_loading)
			ioctl_wait <= 1'b0;
		else if (ioctl_wr)
		begin
			// Hold the source off until the memory takes the word
			wr_req     <= ~wr_req;
			ioctl_wait <= 1'b1;
		end
		else if (ioctl_wait && wr_ack == wr_req)
			ioctl_wait <= 1'b0;
	end

	// Stable while the write is outstanding
	always_ff @(posedge clk_sys)
	begin
		if (pcm_loading && ioctl_wr)
		begin
			wr_addr <= load_addr[adpcm_pkg::PCM_BYTE_ADDR_W-1:1];
			wr_data <= ioctl_dout;
		end
	end

	// Source honours back-pressure
	no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(pcm_loading && ioctl_wait) |-> !ioctl_wr);

endmodule

// File: hdl/adpcm_byte_result.sv
// ADPCM byte result
`timescale 1ns/1ps

module adpcm_byte_result
(
	input  logic                      clk_sys,
	input  logic                      nRESET,
	input  logic                      done,
	input  adpcm_pkg::adpcm_req_t     done_req,
	input  adpcm_pkg::pcm_word_t      rd_data,
	output adpcm_pkg::pcm_byte_t      adpcma_data,
	output adpcm_pkg::pcm_byte_t      adpcmb_data
);

	adpcm_pkg::pcm_byte_t sel_byte;

	// ======================================================================
	// Byte select
	// ======================================================================

	// Odd byte address takes the upper half of the word
	always_comb
	begin
		if (done_req.addr[0])
			sel_byte = rd_data[15:8];
		else
			sel_byte = rd_data[7:0];
	end

	// ======================================================================
	// Channel data hold
	// ======================================================================

	// Held until that channel's next completed read
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			adpcma_data <= '0;
			adpcmb_data <= '0;
		end
		else if (done)
		begin
			if (done_req.chan == adpcm_pkg::chan_b)
				adpcmb_data <= sel_byte;
			else
				adpcma_data <= sel_byte;
		end
	end

endmodule

// File: hdl/adpcm_fetch_exec.sv
// ADPCM fetch execute
`timescale 1ns/1ps

module adpcm_fetch_exec
(
	input  logic                       clk_sys,
	input  logic                       nRESET,
	input  logic                       pend_a,
	input  logic                       pend_b,
	input  adpcm_pkg::adpcm_req_t      req_a,
	input  adpcm_pkg::adpcm_req_t      req_b,
	output logic                       grant,
	output adpcm_pkg::adpcm_chan_t     grant_chan,
	output logic                       rd_req,
	input  logic                       rd_ack,
	output adpcm_pkg::pcm_word_addr_t  rd_addr,
	output logic                       done,
	output adpcm_pkg::adpcm_req_t      done_req
);

	adpcm_pkg::fetch_state_t state;
	adpcm_pkg::adpcm_req_t   cur_req;
	logic                    rd_settled;

	// ======================================================================
	// Arbitration
	// ======================================================================

	// Channel B first, it can run faster than A
	assign grant      = (state == adpcm_pkg::fetch_idle) && (pend_a || pend_b);
	assign grant_chan = pend_b ? adpcm_pkg::chan_b : adpcm_pkg::chan_a;

	// Toggle link has answered
	assign rd_settled = (rd_ack == rd_req);

	// ======================================================================
	// Read transaction
	// ======================================================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state  <= adpcm_pkg::fetch_idle;
			rd_req <= 1'b0;
			done   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				adpcm_pkg::fetch_idle:
				begin
					// Start the read in the grant cycle
					if (grant)
					begin
						rd_req <= ~rd_req;
						state  <= adpcm_pkg::fetch_wait;
					end
				end
				adpcm_pkg::fetch_wait:
				begin
					// Latency varies, wait for ack to catch up
					if (rd_settled)
					begin
						done  <= 1'b1;
						state <= adpcm_pkg::fetch_idle;
					end
				end
				default:
					state <= adpcm_pkg::fetch_idle;
			endcase
		end
	end

	// Granted request, held stable while the read is outstanding
	always_ff @(posedge clk_sys)
	begin
		if (grant)
			cur_req <= (grant_chan == adpcm_pkg::chan_b) ? req_b : req_a;
	end

	// Word address drops the byte select bit
	assign rd_addr  = cur_req.addr[adpcm_pkg::PCM_BYTE_ADDR_W-1:1];
	assign done_req = cur_req;

	// ======================================================================
	// Checks
	// ======================================================================

	// One read at a time, a new toggle only leaves idle
	req_toggle_idle: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$changed(rd_req) |-> $past(state) == adpcm_pkg::fetch_idle);

	state_known: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!$isunknown(state));

endmodule

// File: hdl/adpcm_req_decode.sv
// ADPCM request decode
`timescale 1ns/1ps

module adpcm_req_decode
(
	input  logic                                   clk_sys,
	input  logic                                   nRESET,
	input  logic                                   adpcma_roe_n,
	input  logic                                   adpcmb_roe_n,
	input  logic                                   use_pcm,
	input  logic [adpcm_pkg::ADPCMA_ADDR_W-1:0]    adpcma_addr,
	input  logic [adpcm_pkg::ADPCMA_BANK_W-1:0]    adpcma_bank,
	input  logic [adpcm_pkg::ADPCMB_ADDR_W-1:0]    adpcmb_addr,
	input  logic                                   grant,
	input  adpcm_pkg::adpcm_chan_t                 grant_chan,
	output logic                                   pend_a,
	output logic                                   pend_b,
	output adpcm_pkg::adpcm_req_t                  req_a,
	output adpcm_pkg::adpcm_req_t                  req_b
);

	// Read-enable history, bits 1:0 resample, bit 2 is the previous level
	logic [2:0] roe_a_sr;
	logic [2:0] roe_b_sr;
	logic       fall_a;
	logic       fall_b;

	// ======================================================================
	// Strobe capture
	// ======================================================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			// Read-enables idle high
			roe_a_sr <= 3'b111;
			roe_b_sr <= 3'b111;
		end
		else
		begin
			roe_a_sr <= {roe_a_sr[1:0], adpcma_roe_n};
			roe_b_sr <= {roe_b_sr[1:0], adpcmb_roe_n};
		end
	end

	// High then low, one stage apart
	assign fall_a = roe_a_sr[2] & ~roe_a_sr[1];
	assign fall_b = roe_b_sr[2] & ~roe_b_sr[1];

	// Pending flags, a new edge wins over the grant that clears them
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			pend_a <= 1'b0;
			pend_b <= 1'b0;
		end
		else
		begin
			if (fall_a)
				pend_a <= 1'b1;
			else if (grant && grant_chan == adpcm_pkg::chan_a)
				pend_a <= 1'b0;

			if (fall_b)
				pend_b <= 1'b1;
			else if (grant && grant_chan == adpcm_pkg::chan_b)
				pend_b <= 1'b0;
		end
	end

	// ======================================================================
	// Address forming
	// ======================================================================

	always_comb
	begin
		// Channel A lives in the lower 16 MB, banked by 1 MB
		req_a.chan = adpcm_pkg::chan_a;
		req_a.addr = {1'b0, adpcma_bank, adpcma_addr};
		// Channel B picks the upper or lower half with use_pcm
		req_b.chan = adpcm_pkg::chan_b;
		req_b.addr = {~use_pcm, adpcmb_addr};
	end

	// Execute only grants what is pending here
	grant_pending: assert property (@(posedge clk_sys) disable iff (!nRESET)
		grant |-> ((grant_chan == adpcm_pkg::chan_b) ? pend_b : pend_a));

endmodule

// File: hdl/adpcm_pkg.sv
// ADPCM sample memory definitions

package adpcm_pkg;

	// ======================================================================
	// Widths
	// ======================================================================

	// Memory data word and ADPCM sample byte
	localparam int PCM_WORD_W = 16;
	localparam int PCM_BYTE_W = 8;

	// 32 MB sample memory, byte and word addressing
	localparam int PCM_BYTE_ADDR_W = 25;
	localparam int PCM_WORD_ADDR_W = PCM_BYTE_ADDR_W - 1;

	// YM2610 channel address inputs
	localparam int ADPCMA_ADDR_W = 20;
	localparam int ADPCMA_BANK_W = 4;
	localparam int ADPCMB_ADDR_W = 24;

	// Download port
	localparam int IOCTL_INDEX_W = 8;

	// ======================================================================
	// Download indexes
	// ======================================================================

	// Voice ROMs occupy [INDEX_VROMS, INDEX_CROMS)
	localparam logic [IOCTL_INDEX_W-1:0] INDEX_VROMS = 8'd16;
	localparam logic [IOCTL_INDEX_W-1:0] INDEX_CROMS = 8'd64;

	// Each voice ROM index past the first moves the load address by 512 KB
	localparam int VROM_SLOT_SHIFT = 19;

	// ======================================================================
	// Types
	// ======================================================================

	typedef logic [PCM_WORD_W-1:0]      pcm_word_t;
	typedef logic [PCM_BYTE_W-1:0]      pcm_byte_t;
	typedef logic [PCM_BYTE_ADDR_W-1:0] pcm_byte_addr_t;
	typedef logic [PCM_WORD_ADDR_W-1:0] pcm_word_addr_t;

	typedef enum logic {chan_a = 1'b0, chan_b = 1'b1} adpcm_chan_t;

	// One byte read: who asked and where
	typedef struct packed {
		adpcm_chan_t    chan;
		pcm_byte_addr_t addr;
	} adpcm_req_t;

	typedef enum logic {fetch_idle = 1'b0, fetch_wait = 1'b1} fetch_state_t;

endpackage
